// File: rtl/noc_pkg.sv
`default_nettype none

package noc_pkg;

  localparam int flit_w    = 32;
  localparam int num_ports = 5;

  typedef logic [flit_w-1:0]    flit_t;
  typedef logic [1:0]           flit_kind_t;
  typedef logic [2:0]           coord_t;
  typedef logic [num_ports-1:0] port_sel_t;

  localparam flit_kind_t kind_body   = 2'b00;
  localparam flit_kind_t kind_head   = 2'b01;
  localparam flit_kind_t kind_tail   = 2'b10;
  localparam flit_kind_t kind_single = 2'b11;

  // head flit layout.
  localparam int kind_msb     = 31;
  localparam int kind_lsb     = 30;
  localparam int inv_dest_bit = 29;
  localparam int dest_y_msb   = 28;
  localparam int dest_y_lsb   = 26;
  localparam int dest_x_msb   = 25;
  localparam int dest_x_lsb   = 23;

  localparam port_sel_t port_east  = 5'b00001;
  localparam port_sel_t port_west  = 5'b00010;
  localparam port_sel_t port_north = 5'b00100;
  localparam port_sel_t port_south = 5'b01000;
  localparam port_sel_t port_local = 5'b10000;

  typedef enum logic {
    arb_idle,
    arb_locked
  } arb_state_t;

  function automatic flit_kind_t flit_kind(input flit_t flit);
    return flit[kind_msb:kind_lsb];
  endfunction

  // single counts as both head and tail.
  function automatic logic is_head(input flit_t flit);
    return (flit_kind(flit) == kind_head) || (flit_kind(flit) == kind_single);
  endfunction

  function automatic logic is_tail(input flit_t flit);
    return (flit_kind(flit) == kind_tail) || (flit_kind(flit) == kind_single);
  endfunction

  function automatic coord_t dest_x(input flit_t flit);
    return flit[dest_x_msb:dest_x_lsb];
  endfunction

  function automatic coord_t dest_y(input flit_t flit);
    return flit[dest_y_msb:dest_y_lsb];
  endfunction

endpackage

`default_nettype wire

// File: rtl/noc_input_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module noc_input_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           in_valid,
  input  noc_pkg::flit_t in_flit,
  output logic           in_ready,
  output logic           out_valid,
  output noc_pkg::flit_t out_flit,
  input  logic           out_ready
);
  import noc_pkg::*;

  localparam int ptr_w = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  flit_t            mem [FIFO_DEPTH];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0]   count;
  logic [ptr_w:0]   count_next;
  logic             push;
  logic             pop;

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_comb begin
    count_next = count;
    if (push && !pop) begin
      count_next = count + 1'b1;
    end else if (pop && !push) begin
      count_next = count - 1'b1;
    end
  end

  // ready is registered, so it only looks at next count.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      in_ready <= 1'b1;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_w'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count    <= count_next;
      in_ready <= (count_next != (ptr_w + 1)'(FIFO_DEPTH));
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_flit;
    end
  end

  assign out_valid = (count != '0);
  assign out_flit  = mem[rd_ptr];

endmodule

`default_nettype wire

// File: rtl/noc_route_selector.sv
`timescale 1ns/100ps
`default_nettype none

module noc_route_selector #(
  parameter noc_pkg::coord_t    X               = '0,
  parameter noc_pkg::coord_t    Y               = '0,
  parameter int                 SIZE_X          = 1,
  parameter int                 SIZE_Y          = 1,
  parameter noc_pkg::port_sel_t AVAILABLE_PORTS = '1
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               buf_valid,
  input  noc_pkg::flit_t     buf_flit,
  output logic               buf_ready,
  output noc_pkg::port_sel_t request,
  output noc_pkg::flit_t     sel_flit,
  input  noc_pkg::port_sel_t grant_in,
  input  noc_pkg::port_sel_t out_ready
);
  import noc_pkg::*;

  port_sel_t route_q;
  port_sel_t route_next;
  port_sel_t route;
  logic      head_wait;
  logic      xfer;

  // xy order, x first.
  function automatic port_sel_t select_route(input flit_t flit);
    coord_t dx;
    coord_t dy;
    dx = dest_x(flit);
    dy = dest_y(flit);
    if ((dx > X) && ((AVAILABLE_PORTS & port_east) != '0)) begin
      return port_east;
    end
    if ((dx < X) && ((AVAILABLE_PORTS & port_west) != '0)) begin
      return port_west;
    end
    if ((dy > Y) && ((AVAILABLE_PORTS & port_north) != '0)) begin
      return port_north;
    end
    if ((dy < Y) && ((AVAILABLE_PORTS & port_south) != '0)) begin
      return port_south;
    end
    return port_local;
  endfunction

  function automatic flit_t mark_flit(input flit_t flit);
    flit_t marked;
    marked = flit;
    if (is_head(flit) &&
        ((int'(dest_x(flit)) >= SIZE_X) || (int'(dest_y(flit)) >= SIZE_Y))) begin
      marked[inv_dest_bit] = 1'b1;
    end
    return marked;
  endfunction

  assign head_wait  = buf_valid && is_head(buf_flit);
  assign route_next = select_route(buf_flit);
  assign route      = head_wait ? route_next : route_q;
  assign xfer       = buf_valid && buf_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      route_q <= '0;
    end else if (xfer && is_tail(buf_flit)) begin
      route_q <= '0;
    end else if (xfer && head_wait) begin
      route_q <= route_next;
    end
  end

  assign request   = route & {num_ports{buf_valid}};
  assign buf_ready = |(route & grant_in & out_ready);
  assign sel_flit  = mark_flit(buf_flit);

endmodule

`default_nettype wire

// File: rtl/noc_output_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module noc_output_arbiter (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  noc_pkg::port_sel_t                      request,
  input  noc_pkg::flit_t [noc_pkg::num_ports-1:0] in_flit,
  output noc_pkg::port_sel_t                      grant,
  output logic                                    out_valid,
  output noc_pkg::flit_t                          out_flit,
  input  logic                                    out_ready
);
  import noc_pkg::*;

  localparam int idx_w = $clog2(num_ports);

  arb_state_t       state_q;
  port_sel_t        grant_q;
  logic [idx_w-1:0] last_q;
  logic [idx_w-1:0] grant_idx;
  logic             xfer;
  logic             eop;

  // first requester after the last winner.
  function automatic port_sel_t rr_pick(input port_sel_t req, input logic [idx_w-1:0] ptr);
    port_sel_t pick;
    logic      found;
    int        idx;
    pick  = '0;
    found = 1'b0;
    for (int i = 1; i <= num_ports; i++) begin
      idx = (int'(ptr) + i) % num_ports;
      if (!found && req[idx]) begin
        pick[idx] = 1'b1;
        found     = 1'b1;
      end
    end
    return pick;
  endfunction

  // a stalled grant in idle is kept, so the output stays steady.
  always_comb begin
    if ((state_q == arb_locked) || (grant_q != '0)) begin
      grant = grant_q;
    end else begin
      grant = rr_pick(request, last_q);
    end
  end

  always_comb begin
    grant_idx = '0;
    for (int i = 0; i < num_ports; i++) begin
      if (grant[i]) begin
        grant_idx = idx_w'(i);
      end
    end
  end

  assign out_valid = |(grant & request);
  assign out_flit  = in_flit[grant_idx];
  assign xfer      = out_valid && out_ready;
  assign eop       = xfer && is_tail(out_flit);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= arb_idle;
      grant_q <= '0;
      last_q  <= idx_w'(num_ports - 1);
    end else begin
      case (state_q)
        arb_idle: begin
          if (eop) begin
            grant_q <= '0;
            last_q  <= grant_idx;
          end else if (xfer) begin
            state_q <= arb_locked;
            grant_q <= grant;
          end else if (out_valid) begin
            grant_q <= grant;
          end
        end
        arb_locked: begin
          if (eop) begin
            state_q <= arb_idle;
            grant_q <= '0;
            last_q  <= grant_idx;
          end
        end
        default: begin
          state_q <= arb_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/noc_router.sv
`timescale 1ns/100ps
`default_nettype none

module noc_router #(
  parameter noc_pkg::coord_t    X               = '0,
  parameter noc_pkg::coord_t    Y               = '0,
  parameter int                 SIZE_X          = 3,
  parameter int                 SIZE_Y          = 3,
  parameter noc_pkg::port_sel_t AVAILABLE_PORTS = '1,
  parameter int                 FIFO_DEPTH      = 4
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic [noc_pkg::num_ports-1:0]           in_valid,
  input  noc_pkg::flit_t [noc_pkg::num_ports-1:0] in_flit,
  output logic [noc_pkg::num_ports-1:0]           in_ready,
  output logic [noc_pkg::num_ports-1:0]           out_valid,
  output noc_pkg::flit_t [noc_pkg::num_ports-1:0] out_flit,
  input  logic [noc_pkg::num_ports-1:0]           out_ready
);
  import noc_pkg::*;

  logic [num_ports-1:0]  buf_valid;
  flit_t [num_ports-1:0] buf_flit;
  logic [num_ports-1:0]  buf_ready;
  flit_t [num_ports-1:0] sel_flit;
  // indexed by input, one bit per output.
  port_sel_t             request [num_ports];
  port_sel_t             grant_in [num_ports];

  for (genvar i = 0; i < num_ports; i++) begin : g_in
    noc_input_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid[i]),
      .in_flit   (in_flit[i]),
      .in_ready  (in_ready[i]),
      .out_valid (buf_valid[i]),
      .out_flit  (buf_flit[i]),
      .out_ready (buf_ready[i])
    );

    noc_route_selector #(
      .X               (X),
      .Y               (Y),
      .SIZE_X          (SIZE_X),
      .SIZE_Y          (SIZE_Y),
      .AVAILABLE_PORTS (AVAILABLE_PORTS)
    ) u_selector (
      .clk       (clk),
      .rst_n     (rst_n),
      .buf_valid (buf_valid[i]),
      .buf_flit  (buf_flit[i]),
      .buf_ready (buf_ready[i]),
      .request   (request[i]),
      .sel_flit  (sel_flit[i]),
      .grant_in  (grant_in[i]),
      .out_ready (out_ready)
    );
  end

  for (genvar o = 0; o < num_ports; o++) begin : g_out
    if (AVAILABLE_PORTS[o]) begin : g_arb
      port_sel_t arb_req;
      port_sel_t arb_grant;

      // transpose between input-major and output-major.
      for (genvar i = 0; i < num_ports; i++) begin : g_xbar
        assign arb_req[i]     = request[i][o];
        assign grant_in[i][o] = arb_grant[i];
      end

      noc_output_arbiter u_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .request   (arb_req),
        .in_flit   (sel_flit),
        .grant     (arb_grant),
        .out_valid (out_valid[o]),
        .out_flit  (out_flit[o]),
        .out_ready (out_ready[o])
      );
    end else begin : g_off
      for (genvar i = 0; i < num_ports; i++) begin : g_xbar
        assign grant_in[i][o] = 1'b0;
      end
      assign out_valid[o] = 1'b0;
      assign out_flit[o]  = '0;
    end
  end

endmodule

`default_nettype wire

// File: bench/noc_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module noc_clock_gen #(
  parameter int PERIOD = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD / 2) clk = ~clk;
    end
  end

endmodule

`default_nettype wire

// File: bench/noc_router_checker.sv
`timescale 1ns/100ps
`default_nettype none

module noc_router_checker (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic [noc_pkg::num_ports-1:0]           out_valid,
  input  noc_pkg::flit_t [noc_pkg::num_ports-1:0] out_flit,
  input  logic [noc_pkg::num_ports-1:0]           out_ready
);
  import noc_pkg::*;

  // set between a head handshake and its tail.
  logic [num_ports-1:0] in_pkt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_pkt <= '0;
    end else begin
      for (int o = 0; o < num_ports; o++) begin
        if (out_valid[o] && out_ready[o]) begin
          in_pkt[o] <= (out_flit[o][kind_msb:kind_lsb] == kind_head) ||
                       (in_pkt[o] && (out_flit[o][kind_msb:kind_lsb] == kind_body));
        end
      end
    end
  end

  for (genvar o = 0; o < num_ports; o++) begin : g_port
    flit_kind_t kind;

    assign kind = out_flit[o][kind_msb:kind_lsb];

    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (out_valid[o] && !out_ready[o]) |=> (out_valid[o] && $stable(out_flit[o])))
      else $error("output %0d changed while stalled", o);

    a_reset_idle: assert property (@(posedge clk) !rst_n |-> !out_valid[o])
      else $error("output %0d valid during reset", o);

    a_no_interleave: assert property (@(posedge clk) disable iff (!rst_n)
      (in_pkt[o] && out_valid[o]) |-> ((kind == kind_body) || (kind == kind_tail)))
      else $error("output %0d started a new packet before the tail", o);
  end

endmodule

`default_nettype wire

// File: bench/noc_router_tb.sv
`timescale 1ns/100ps
`default_nettype none

module noc_router_tb;
  import noc_pkg::*;

  localparam coord_t router_x    = 3'd1;
  localparam coord_t router_y    = 3'd1;
  localparam int     mesh_x      = 3;
  localparam int     mesh_y      = 3;
  localparam int     fifo_depth  = 4;
  localparam int     pkts_random = 24;
  localparam int     pkts_local  = 6;
  localparam int     local_idx   = 4;

  logic                  clk;
  logic                  rst_n;
  logic [num_ports-1:0]  in_valid;
  flit_t [num_ports-1:0] in_flit;
  logic [num_ports-1:0]  in_ready;
  logic [num_ports-1:0]  out_valid;
  flit_t [num_ports-1:0] out_flit;
  logic [num_ports-1:0]  out_ready;

  integer    seed;
  int        cycles      = 0;
  int        flits_sent  = 0;
  logic      local_phase = 1'b0;
  int        seq_no [num_ports];
  // expected flits per source and output.
  flit_t     exp_flit_q [num_ports*num_ports][$];
  port_sel_t exp_port_q [num_ports][$];
  port_sel_t cur_port [num_ports];
  int        out_owner [num_ports];
  int        last_served [num_ports];
  int        local_pkts;
  // flits held in each input fifo.
  int        fifo_fill [num_ports];

  noc_clock_gen #(.PERIOD(40)) u_clk (.clk(clk));

  noc_router #(
    .X               (router_x),
    .Y               (router_y),
    .SIZE_X          (mesh_x),
    .SIZE_Y          (mesh_y),
    .AVAILABLE_PORTS (5'b11111),
    .FIFO_DEPTH      (fifo_depth)
  ) uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_flit   (in_flit),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_flit  (out_flit),
    .out_ready (out_ready)
  );

  bind noc_router noc_router_checker u_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .out_valid (out_valid),
    .out_flit  (out_flit),
    .out_ready (out_ready)
  );

  // xy order, x first.
  function automatic port_sel_t expected_port(input flit_t head);
    coord_t dx;
    coord_t dy;
    dx = head[25:23];
    dy = head[28:26];
    if (dx > router_x) return port_east;
    if (dx < router_x) return port_west;
    if (dy > router_y) return port_north;
    if (dy < router_y) return port_south;
    return port_local;
  endfunction

  function automatic flit_t expected_flit(input flit_t sent);
    flit_t want;
    logic  head;
    want = sent;
    head = (sent[31:30] == kind_head) || (sent[31:30] == kind_single);
    if (head && ((int'(sent[25:23]) >= mesh_x) || (int'(sent[28:26]) >= mesh_y))) begin
      want[29] = 1'b1;
    end
    return want;
  endfunction

  // an input accepts while its fifo has room.
  function automatic logic [num_ports-1:0] expected_ready();
    logic [num_ports-1:0] ready;
    for (int p = 0; p < num_ports; p++) begin
      ready[p] = (fifo_fill[p] != fifo_depth);
    end
    return ready;
  endfunction

  // source port and sequence number sit in the payload.
  function automatic flit_t make_flit(input flit_kind_t kind, input int src, input coord_t dx,
                                      input coord_t dy, input int seq);
    return {kind, 1'b0, dy, dx, 3'(src), 20'(seq)};
  endfunction

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic int port_index(input port_sel_t sel);
    int idx;
    idx = 0;
    for (int i = 0; i < num_ports; i++) begin
      if (sel[i]) idx = i;
    end
    return idx;
  endfunction

  function automatic logic queues_empty();
    logic empty;
    empty = 1'b1;
    for (int i = 0; i < num_ports * num_ports; i++) begin
      if (exp_flit_q[i].size() != 0) empty = 1'b0;
    end
    for (int p = 0; p < num_ports; p++) begin
      if (exp_port_q[p].size() != 0) empty = 1'b0;
    end
    return empty;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_flit(input flit_t actual, input flit_t expected, input int o);
    if (actual !== expected) begin
      abort_run($sformatf("Fail at %0t: output %0d carried flit %h, expected %h",
                          $time, o, actual, expected));
    end
  endtask

  task automatic check_port(input port_sel_t actual, input port_sel_t expected, input int src);
    if (actual !== expected) begin
      abort_run($sformatf("Fail at %0t: flit from input %0d left at port %b, expected %b",
                          $time, src, actual, expected));
    end
  endtask

  task automatic check_ready(input logic [num_ports-1:0] actual,
                             input logic [num_ports-1:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("Fail at %0t: in_ready was %b, expected %b",
                          $time, actual, expected));
    end
  endtask

  task automatic record_input(input int p, input flit_t f);
    if ((f[31:30] == kind_head) || (f[31:30] == kind_single)) begin
      cur_port[p] = expected_port(f);
    end
    exp_port_q[p].push_back(cur_port[p]);
    exp_flit_q[p*num_ports + port_index(cur_port[p])].push_back(expected_flit(f));
    fifo_fill[p]++;
    flits_sent++;
  endtask

  task automatic check_output(input int o, input flit_t f);
    int         src;
    flit_kind_t kind;
    src  = int'(f[22:20]);
    kind = f[31:30];
    if ((src >= num_ports) || (exp_port_q[src].size() == 0)) begin
      abort_run($sformatf("output %0d delivered a flit that no input sent", o));
    end
    fifo_fill[src]--;
    check_port(port_sel_t'(1 << o), exp_port_q[src].pop_front(), src);
    check_flit(f, exp_flit_q[src*num_ports + o].pop_front(), o);
    if ((out_owner[o] >= 0) && (out_owner[o] != src)) begin
      abort_run($sformatf("output %0d mixed a flit from input %0d into a packet from input %0d",
                          o, src, out_owner[o]));
    end
    if (kind == kind_head) begin
      out_owner[o] = src;
    end else if ((kind == kind_tail) || (kind == kind_single)) begin
      out_owner[o] = -1;
    end
    // every input gets a turn within five packets.
    if (local_phase && (o == local_idx) && ((kind == kind_head) || (kind == kind_single))) begin
      if (local_pkts - last_served[src] > num_ports) begin
        abort_run($sformatf("input %0d waited more than five packets for the local port", src));
      end
      last_served[src] = local_pkts;
      local_pkts++;
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      for (int p = 0; p < num_ports; p++) begin
        out_owner[p]   = -1;
        last_served[p] = -1;
        cur_port[p]    = '0;
        fifo_fill[p]   = 0;
      end
      local_pkts = 0;
    end else begin
      check_ready(in_ready, expected_ready());
      for (int p = 0; p < num_ports; p++) begin
        if (in_valid[p] && in_ready[p]) record_input(p, in_flit[p]);
      end
      for (int o = 0; o < num_ports; o++) begin
        if (out_valid[o] && out_ready[o]) check_output(o, out_flit[o]);
      end
    end
  end

  always @(negedge clk) begin
    cycles++;
    if (cycles > 20 * flits_sent + 200) begin
      abort_run($sformatf("the run timed out after %0d cycles", cycles));
    end
  end

  task automatic run_traffic(input int npkts, input logic to_local);
    int         pkts_left [num_ports];
    int         flits_left [num_ports];
    int         pkt_len [num_ports];
    coord_t     dx [num_ports];
    coord_t     dy [num_ports];
    logic       taken [num_ports];
    logic       busy;
    flit_kind_t kind;
    for (int p = 0; p < num_ports; p++) begin
      pkts_left[p]  = npkts;
      flits_left[p] = 0;
      taken[p]      = 1'b0;
    end
    busy = 1'b1;
    while (busy) begin
      @(negedge clk);
      busy = 1'b0;
      for (int o = 0; o < num_ports; o++) begin
        out_ready[o] = to_local || (rand_below(4) != 0);
      end
      for (int p = 0; p < num_ports; p++) begin
        // in_ready is registered, so last cycle's value decided the handshake.
        if (taken[p]) in_valid[p] = 1'b0;
        if (!in_valid[p] && (to_local || (rand_below(4) != 0))) begin
          if ((flits_left[p] == 0) && (pkts_left[p] > 0)) begin
            pkt_len[p]    = 1 + rand_below(4);
            flits_left[p] = pkt_len[p];
            pkts_left[p]--;
            dx[p] = to_local ? router_x : coord_t'(rand_below(5));
            dy[p] = to_local ? router_y : coord_t'(rand_below(5));
          end
          if (flits_left[p] > 0) begin
            if (pkt_len[p] == 1) begin
              kind = kind_single;
            end else if (flits_left[p] == pkt_len[p]) begin
              kind = kind_head;
            end else if (flits_left[p] == 1) begin
              kind = kind_tail;
            end else begin
              kind = kind_body;
            end
            in_flit[p]  = make_flit(kind, p, dx[p], dy[p], seq_no[p]);
            in_valid[p] = 1'b1;
            seq_no[p]++;
            flits_left[p]--;
          end
        end
        taken[p] = in_valid[p] && in_ready[p];
        if (in_valid[p] || (flits_left[p] > 0) || (pkts_left[p] > 0)) busy = 1'b1;
      end
    end
  endtask

  task automatic wait_drained();
    @(negedge clk);
    out_ready = '1;
    while (!queues_empty()) begin
      @(negedge clk);
    end
    // extra cycles expose duplicated flits.
    repeat (8) @(negedge clk);
  endtask

  initial begin
    seed      = 26;
    rst_n     = 1'b0;
    in_valid  = '0;
    in_flit   = '0;
    out_ready = '0;
    for (int p = 0; p < num_ports; p++) begin
      seq_no[p] = 0;
    end
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    run_traffic(pkts_random, 1'b0);
    wait_drained();
    local_phase = 1'b1;
    run_traffic(pkts_local, 1'b1);
    wait_drained();
    if (queues_empty() && (local_pkts == num_ports * pkts_local)) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      abort_run("not every packet of the local phase reached the local port");
    end
  end

endmodule

`default_nettype wire

// File: compile.f
rtl/noc_pkg.sv
rtl/noc_input_fifo.sv
rtl/noc_route_selector.sv
rtl/noc_output_arbiter.sv
rtl/noc_router.sv
bench/noc_clock_gen.sv
bench/noc_router_checker.sv
bench/noc_router_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module noc_router_tb -Mdir obj_dir -f compile.f

output=$(./obj_dir/Vnoc_router_tb 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Simulation completed successfully"; then
  exit 0
else
  exit 1
fi
